// File: design/id_pkg.sv
// decode stage shared definitions
package id_pkg;

  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;

  typedef logic [GPR_ADDR_WD-1:0] gpr_addr_t;
  typedef logic [XLEN-1:0]        xlen_t;
  typedef logic [INST_WD-1:0]     inst_t;

  typedef enum logic [1:0] {
    ALU_ADD    = 2'b00,
    ALU_SUB    = 2'b01,
    ALU_PASS_B = 2'b10  // lui
  } alu_op_t;

  // conditional branches reuse funct3, jumps take the two spare codes
  typedef enum logic [2:0] {
    BR_EQ   = 3'b000,
    BR_NE   = 3'b001,
    BR_JAL  = 3'b010,
    BR_JALR = 3'b011,
    BR_LT   = 3'b100,
    BR_GE   = 3'b101,
    BR_LTU  = 3'b110,
    BR_GEU  = 3'b111
  } br_func_t;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  localparam logic [2:0] F3_ADD    = 3'b000;  // add, sub, addi, jalr
  localparam logic [2:0] F3_DOUBLE = 3'b011;  // ld, sd
  localparam logic [6:0] F7_ADD    = 7'b0000000;
  localparam logic [6:0] F7_SUB    = 7'b0100000;

  // alu operand 2 select
  localparam logic [1:0] SRC2_RS2  = 2'b00;
  localparam logic [1:0] SRC2_IMM  = 2'b01;
  localparam logic [1:0] SRC2_FOUR = 2'b10;  // link address pc + 4

  localparam inst_t NOP_INST = 32'h0000_0013;  // addi x0, x0, 0

endpackage

// File: design/id_gpr_file.sv
// general register file
`timescale 1ns/1ps

module id_gpr_file (
  input  logic              i_clk,
  input  id_pkg::gpr_addr_t i_raddr1,
  output id_pkg::xlen_t     o_rdata1,
  input  id_pkg::gpr_addr_t i_raddr2,
  output id_pkg::xlen_t     o_rdata2,
  input  logic              i_wen,
  input  id_pkg::gpr_addr_t i_waddr,
  input  id_pkg::xlen_t     i_wdata
);
  import id_pkg::*;

  xlen_t regs [2**GPR_ADDR_WD];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin  // x0 stays unwritten
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// File: design/id_operand_fetch.sv
// register read and forwarding
`timescale 1ns/1ps

module id_operand_fetch (
  input  logic              i_clk,
  input  id_pkg::gpr_addr_t i_rs1,
  input  id_pkg::gpr_addr_t i_rs2,
  input  logic              i_ws_gpr_wen,
  input  id_pkg::gpr_addr_t i_ws_gpr_waddr,
  input  id_pkg::xlen_t     i_ws_gpr_wdata,
  input  id_pkg::gpr_addr_t i_es_byp_rd,
  input  id_pkg::xlen_t     i_es_byp_result,
  input  id_pkg::gpr_addr_t i_ms_byp_rd,
  input  id_pkg::xlen_t     i_ms_byp_result,
  input  id_pkg::gpr_addr_t i_ws_byp_rd,
  input  id_pkg::xlen_t     i_ws_byp_result,
  output id_pkg::xlen_t     o_rs1_data,
  output id_pkg::xlen_t     o_rs2_data
);
  import id_pkg::*;

  xlen_t rf_rdata1;
  xlen_t rf_rdata2;

  // nearest producer wins
  function automatic xlen_t fwd_pick(input gpr_addr_t idx, input xlen_t rf_val);
    if (i_es_byp_rd != '0 && i_es_byp_rd == idx) begin
      return i_es_byp_result;
    end else if (i_ms_byp_rd != '0 && i_ms_byp_rd == idx) begin
      return i_ms_byp_result;
    end else if (i_ws_byp_rd != '0 && i_ws_byp_rd == idx) begin
      return i_ws_byp_result;
    end
    return rf_val;
  endfunction

  always_comb begin
    o_rs1_data = fwd_pick(i_rs1, rf_rdata1);
    o_rs2_data = fwd_pick(i_rs2, rf_rdata2);
  end

  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_raddr1 (i_rs1),
    .o_rdata1 (rf_rdata1),
    .i_raddr2 (i_rs2),
    .o_rdata2 (rf_rdata2),
    .i_wen    (i_ws_gpr_wen),
    .i_waddr  (i_ws_gpr_waddr),
    .i_wdata  (i_ws_gpr_wdata)
  );

endmodule

// File: design/id_decoder.sv
// rv64i subset decoder
`timescale 1ns/1ps

module id_decoder (
  input  id_pkg::inst_t     i_inst,
  output id_pkg::gpr_addr_t o_rs1,
  output id_pkg::gpr_addr_t o_rs2,
  output id_pkg::gpr_addr_t o_rd,
  output id_pkg::xlen_t     o_imm,
  output logic              o_bren,
  output id_pkg::br_func_t  o_br_func,
  output id_pkg::alu_op_t   o_alu_op,
  output logic              o_alu_src1_sel,
  output logic [1:0]        o_alu_src2_sel,
  output logic              o_gpr_wen,
  output logic              o_mem_ren,
  output logic              o_mem_wen,
  output logic              o_load_sel,
  output logic              o_invalid
);
  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  logic       use_rs1;
  logic       use_rs2;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                  i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
                  i_inst[20], i_inst[30:21], 1'b0};

  // unused source fields read x0 so they never stall or forward
  assign o_rs1 = use_rs1 ? i_inst[19:15] : '0;
  assign o_rs2 = use_rs2 ? i_inst[24:20] : '0;
  assign o_rd  = o_gpr_wen ? i_inst[11:7] : '0;

  always_comb begin
    use_rs1        = 1'b0;
    use_rs2        = 1'b0;
    o_imm          = '0;
    o_bren         = 1'b0;
    o_br_func      = BR_EQ;
    o_alu_op       = ALU_ADD;
    o_alu_src1_sel = 1'b0;
    o_alu_src2_sel = SRC2_RS2;
    o_gpr_wen      = 1'b0;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_load_sel     = 1'b0;
    o_invalid      = 1'b0;
    case (opcode)
      OPC_LUI: begin
        o_imm          = imm_u;
        o_alu_op       = ALU_PASS_B;
        o_alu_src2_sel = SRC2_IMM;
        o_gpr_wen      = 1'b1;
      end
      OPC_JAL: begin
        o_imm          = imm_j;
        o_bren         = 1'b1;
        o_br_func      = BR_JAL;
        o_alu_src1_sel = 1'b1;   // rd = pc + 4
        o_alu_src2_sel = SRC2_FOUR;
        o_gpr_wen      = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == F3_ADD) begin
          use_rs1        = 1'b1;
          o_imm          = imm_i;
          o_bren         = 1'b1;
          o_br_func      = BR_JALR;
          o_alu_src1_sel = 1'b1;
          o_alu_src2_sel = SRC2_FOUR;
          o_gpr_wen      = 1'b1;
        end else begin
          o_invalid = 1'b1;
        end
      end
      OPC_BRANCH: begin
        if (funct3 == 3'b010 || funct3 == 3'b011) begin
          o_invalid = 1'b1;  // those slots are the jump codes
        end else begin
          use_rs1   = 1'b1;
          use_rs2   = 1'b1;
          o_imm     = imm_b;
          o_bren    = 1'b1;
          o_br_func = br_func_t'(funct3);
        end
      end
      OPC_LOAD: begin
        if (funct3 == F3_DOUBLE) begin
          use_rs1        = 1'b1;
          o_imm          = imm_i;
          o_alu_src2_sel = SRC2_IMM;
          o_gpr_wen      = 1'b1;
          o_mem_ren      = 1'b1;
          o_load_sel     = 1'b1;
        end else begin
          o_invalid = 1'b1;
        end
      end
      OPC_STORE: begin
        if (funct3 == F3_DOUBLE) begin
          use_rs1        = 1'b1;
          use_rs2        = 1'b1;
          o_imm          = imm_s;
          o_alu_src2_sel = SRC2_IMM;
          o_mem_wen      = 1'b1;
        end else begin
          o_invalid = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        if (funct3 == F3_ADD) begin
          use_rs1        = 1'b1;
          o_imm          = imm_i;
          o_alu_src2_sel = SRC2_IMM;
          o_gpr_wen      = 1'b1;
        end else begin
          o_invalid = 1'b1;
        end
      end
      OPC_OP: begin
        if (funct3 == F3_ADD && (funct7 == F7_ADD || funct7 == F7_SUB)) begin
          use_rs1   = 1'b1;
          use_rs2   = 1'b1;
          o_alu_op  = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
          o_gpr_wen = 1'b1;
        end else begin
          o_invalid = 1'b1;
        end
      end
      default: o_invalid = 1'b1;
    endcase
    if (i_inst[11:7] == '0) begin
      o_gpr_wen = 1'b0;  // x0 target writes nothing
    end
  end

endmodule

// File: design/id_stage_ctrl.sv
// decode slot control
`timescale 1ns/1ps

module id_stage_ctrl (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_es_allowin,
  input  logic              i_fs_to_ds_valid,
  input  id_pkg::inst_t     i_fs_inst,
  input  id_pkg::xlen_t     i_fs_pc,
  input  logic              i_br_taken,
  input  logic              i_es_load_sel,
  input  id_pkg::gpr_addr_t i_es_byp_rd,
  input  id_pkg::gpr_addr_t i_rs1,
  input  id_pkg::gpr_addr_t i_rs2,
  output logic              o_ds_allowin,
  output logic              o_ds_to_es_valid,
  output id_pkg::inst_t     o_ds_inst,
  output id_pkg::xlen_t     o_ds_pc
);
  import id_pkg::*;

  logic ds_valid;
  logic load_stall;
  logic ds_ready_go;
  logic ds_accept;

  // load result not ready until it reaches mem
  assign load_stall = i_es_load_sel && (i_es_byp_rd != '0) &&
                      ((i_es_byp_rd == i_rs1) || (i_es_byp_rd == i_rs2));

  assign ds_ready_go      = ~load_stall;
  assign o_ds_allowin     = ~ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  assign ds_accept        = i_fs_to_ds_valid && o_ds_allowin;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid  <= 1'b0;
      o_ds_inst <= NOP_INST;
      o_ds_pc   <= '0;
    end else begin
      if (o_ds_allowin) begin
        ds_valid <= i_fs_to_ds_valid;
      end
      if (ds_accept) begin
        // wrong-path fetch becomes a nop at its own pc
        o_ds_inst <= i_br_taken ? NOP_INST : i_fs_inst;
        o_ds_pc   <= i_fs_pc;
      end
    end
  end

endmodule

// File: design/id_branch_unit.sv
// branch resolve and redirect
`timescale 1ns/1ps

module id_branch_unit (
  input  logic             i_ds_fire,
  input  logic             i_bren,
  input  id_pkg::br_func_t i_br_func,
  input  id_pkg::xlen_t    i_rs1_data,
  input  id_pkg::xlen_t    i_rs2_data,
  input  id_pkg::xlen_t    i_pc,
  input  id_pkg::xlen_t    i_imm,
  input  id_pkg::xlen_t    i_fs_pc,
  output logic             o_br_sel,
  output logic             o_br_taken,
  output id_pkg::xlen_t    o_br_target
);
  import id_pkg::*;

  logic  cond;
  logic  lt_s;
  logic  lt_u;
  xlen_t jalr_sum;

  assign lt_s     = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign lt_u     = i_rs1_data < i_rs2_data;
  assign jalr_sum = i_rs1_data + i_imm;

  always_comb begin
    case (i_br_func)
      BR_EQ:   cond = (i_rs1_data == i_rs2_data);
      BR_NE:   cond = (i_rs1_data != i_rs2_data);
      BR_LT:   cond = lt_s;
      BR_GE:   cond = ~lt_s;
      BR_LTU:  cond = lt_u;
      BR_GEU:  cond = ~lt_u;
      default: cond = 1'b1;  // jal, jalr always go
    endcase
  end

  assign o_br_target = (i_br_func == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                              : i_pc + i_imm;

  assign o_br_sel   = i_ds_fire && i_bren && cond;
  // fetch already on the target means nothing to flush
  assign o_br_taken = o_br_sel && (o_br_target != i_fs_pc);

endmodule

// File: design/id_stage.sv
// decode stage top
`timescale 1ns/1ps

module id_stage (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_es_allowin,
  input  logic              i_fs_to_ds_valid,
  input  id_pkg::inst_t     i_fs_inst,
  input  id_pkg::xlen_t     i_fs_pc,
  input  logic              i_ws_gpr_wen,
  input  id_pkg::gpr_addr_t i_ws_gpr_waddr,
  input  id_pkg::xlen_t     i_ws_gpr_wdata,
  input  id_pkg::gpr_addr_t i_es_byp_rd,
  input  id_pkg::gpr_addr_t i_ms_byp_rd,
  input  id_pkg::gpr_addr_t i_ws_byp_rd,
  input  id_pkg::xlen_t     i_es_byp_result,
  input  id_pkg::xlen_t     i_ms_byp_result,
  input  id_pkg::xlen_t     i_ws_byp_result,
  input  logic              i_es_load_sel,
  output logic              o_ds_allowin,
  output logic              o_ds_to_es_valid,
  output id_pkg::xlen_t     o_es_rs1_data,
  output id_pkg::xlen_t     o_es_rs2_data,
  output id_pkg::xlen_t     o_es_imm,
  output id_pkg::xlen_t     o_es_pc,
  output id_pkg::alu_op_t   o_es_alu_op,
  output logic              o_es_alu_src1_sel,
  output logic [1:0]        o_es_alu_src2_sel,
  output id_pkg::gpr_addr_t o_es_rd,
  output logic              o_es_gpr_wen,
  output logic              o_es_mem_ren,
  output logic              o_es_mem_wen,
  output logic              o_es_load_sel,
  output logic              o_es_invalid,
  output logic              o_br_taken,
  output logic              o_br_sel,
  output id_pkg::xlen_t     o_br_target
);
  import id_pkg::*;

  inst_t     ds_inst;
  gpr_addr_t rs1;
  gpr_addr_t rs2;
  logic      bren;
  br_func_t  br_func;

  id_stage_ctrl u_ctrl (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_es_allowin     (i_es_allowin),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_br_taken       (o_br_taken),
    .i_es_load_sel    (i_es_load_sel),
    .i_es_byp_rd      (i_es_byp_rd),
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_inst        (ds_inst),
    .o_ds_pc          (o_es_pc)
  );

  id_decoder u_decoder (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_es_rd),
    .o_imm          (o_es_imm),
    .o_bren         (bren),
    .o_br_func      (br_func),
    .o_alu_op       (o_es_alu_op),
    .o_alu_src1_sel (o_es_alu_src1_sel),
    .o_alu_src2_sel (o_es_alu_src2_sel),
    .o_gpr_wen      (o_es_gpr_wen),
    .o_mem_ren      (o_es_mem_ren),
    .o_mem_wen      (o_es_mem_wen),
    .o_load_sel     (o_es_load_sel),
    .o_invalid      (o_es_invalid)
  );

  id_operand_fetch u_operand_fetch (
    .i_clk           (i_clk),
    .i_rs1           (rs1),
    .i_rs2           (rs2),
    .i_ws_gpr_wen    (i_ws_gpr_wen),
    .i_ws_gpr_waddr  (i_ws_gpr_waddr),
    .i_ws_gpr_wdata  (i_ws_gpr_wdata),
    .i_es_byp_rd     (i_es_byp_rd),
    .i_es_byp_result (i_es_byp_result),
    .i_ms_byp_rd     (i_ms_byp_rd),
    .i_ms_byp_result (i_ms_byp_result),
    .i_ws_byp_rd     (i_ws_byp_rd),
    .i_ws_byp_result (i_ws_byp_result),
    .o_rs1_data      (o_es_rs1_data),
    .o_rs2_data      (o_es_rs2_data)
  );

  id_branch_unit u_branch_unit (
    .i_ds_fire   (o_ds_to_es_valid),
    .i_bren      (bren),
    .i_br_func   (br_func),
    .i_rs1_data  (o_es_rs1_data),
    .i_rs2_data  (o_es_rs2_data),
    .i_pc        (o_es_pc),
    .i_imm       (o_es_imm),
    .i_fs_pc     (i_fs_pc),
    .o_br_sel    (o_br_sel),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

endmodule

// File: testbench/tb_id_vectors.svh
// decode test vectors
localparam xlen_t PB = 64'h1000;  // branch block
localparam xlen_t PJ = 64'h2000;  // jumps
localparam xlen_t PA = 64'h0040;

typedef struct packed {
  inst_t      inst;
  xlen_t      pc;
  xlen_t      fs_pc;       // fetch pc while the entry is checked
  gpr_addr_t  es_rd;
  gpr_addr_t  ms_rd;
  gpr_addr_t  ws_rd;
  logic       load;
  logic       es_allowin;
  logic       squash;      // follower sent while the branch resolves
  logic       exp_valid;
  xlen_t      exp_rs1;
  xlen_t      exp_rs2;
  xlen_t      exp_imm;
  gpr_addr_t  exp_rd;
  logic [4:0] exp_en;      // gpr_wen mem_ren mem_wen load_sel invalid
  logic [4:0] exp_alu;     // alu_op src1_sel src2_sel
  logic       exp_sel;
  logic       exp_taken;
  xlen_t      exp_target;
} vec_t;

vec_t vecs [18];

// x1 forwarded as ES_VAL, x2 as MS_VAL for the branches
task automatic build_vectors();
  vecs = '{
    '{32'h00208863, PB, PB+4, 1, 2, 0, 0, 1, 0, 1, ES_VAL, MS_VAL, 16, 0, 0, 0, 0, 0, PB+16},
    '{32'h00209863, PB, PB+4, 1, 2, 0, 0, 1, 0, 1, ES_VAL, MS_VAL, 16, 0, 0, 0, 1, 1, PB+16},
    '{32'h0020C863, PB, PB+4, 1, 2, 0, 0, 1, 1, 1, ES_VAL, MS_VAL, 16, 0, 0, 0, 1, 1, PB+16},
    '{32'h0020D863, PB, PB+4, 1, 2, 0, 0, 1, 0, 1, ES_VAL, MS_VAL, 16, 0, 0, 0, 0, 0, PB+16},
    '{32'h0020E863, PB, PB+4, 1, 2, 0, 0, 1, 0, 1, ES_VAL, MS_VAL, 16, 0, 0, 0, 0, 0, PB+16},
    '{32'h0020F863, PB, PB+16, 1, 2, 0, 0, 1, 0, 1, ES_VAL, MS_VAL, 16, 0, 0, 0, 1, 0, PB+16},
    '{32'h100000EF, PJ, PJ+4, 0, 0, 0, 0, 1, 1, 1, 0, 0, 64'h100, 1, 5'b10000, 5'b00110,
      1, 1, PJ+64'h100},
    '{32'h005180E7, PJ, PJ+4, 0, 0, 3, 0, 1, 0, 1, WS_VAL, 0, 5, 1, 5'b10000, 5'b00110,
      1, 1, 64'h3004},
    '{32'h003002B3, PA, PA+4, 0, 0, 0, 0, 1, 0, 1, 0, rf[3], 0, 5, 5'b10000, 5'b00000,
      0, 0, 0},
    '{32'h002082B3, PA, PA+4, 1, 1, 2, 0, 1, 0, 1, ES_VAL, WS_VAL, 0, 5, 5'b10000, 5'b00000,
      0, 0, 0},
    '{32'h002082B3, PA, PA+4, 0, 1, 1, 0, 1, 0, 1, MS_VAL, rf[2], 0, 5, 5'b10000, 5'b00000,
      0, 0, 0},
    '{32'h40208333, PA, PA+4, 0, 0, 0, 0, 0, 0, 1, rf[1], rf[2], 0, 6, 5'b10000, 5'b01000,
      0, 0, 0},
    '{32'h002082B3, PA, PA+4, 2, 0, 0, 1, 1, 0, 0, rf[1], ES_VAL, 0, 5, 5'b10000, 5'b00000,
      0, 0, 0},
    '{32'h123453B7, PA, PA+4, 0, 0, 0, 0, 1, 0, 1, 0, 0, 64'h12345000, 7, 5'b10000,
      5'b10001, 0, 0, 0},
    '{32'hFF80B403, PA, PA+4, 0, 0, 0, 0, 1, 0, 1, rf[1], 0, 64'hFFFF_FFFF_FFFF_FFF8,
      8, 5'b11010, 5'b00001, 0, 0, 0},
    '{32'h0020BC23, PA, PA+4, 0, 0, 0, 0, 1, 0, 1, rf[1], rf[2], 24, 0, 5'b00100,
      5'b00001, 0, 0, 0},
    '{32'hFFF08493, PA, PA+4, 0, 0, 0, 0, 1, 0, 1, rf[1], 0, 64'hFFFF_FFFF_FFFF_FFFF,
      9, 5'b10000, 5'b00001, 0, 0, 0},
    '{32'h0000007F, PA, PA+4, 0, 0, 0, 0, 1, 0, 1, 0, 0, 0, 0, 5'b00001, 5'b00000,
      0, 0, 0}
  };
endtask

// File: testbench/tb_id_stage.sv
// decode stage testbench
`timescale 1ns/1ps

module tb_id_stage;
  import id_pkg::*;

  localparam xlen_t ES_VAL   = 64'hFFFF_FFFF_FFFF_FFFB;  // -5
  localparam xlen_t MS_VAL   = 64'd7;
  localparam xlen_t WS_VAL   = 64'h3000;
  localparam int    WAIT_MAX = 20;

  logic      i_clk, i_rst, i_es_allowin, i_fs_to_ds_valid, i_ws_gpr_wen, i_es_load_sel;
  inst_t     i_fs_inst;
  xlen_t     i_fs_pc, i_ws_gpr_wdata, i_es_byp_result, i_ms_byp_result, i_ws_byp_result;
  gpr_addr_t i_ws_gpr_waddr, i_es_byp_rd, i_ms_byp_rd, i_ws_byp_rd;
  logic      o_ds_allowin, o_ds_to_es_valid, o_es_alu_src1_sel, o_es_gpr_wen, o_es_mem_ren;
  logic      o_es_mem_wen, o_es_load_sel, o_es_invalid, o_br_taken, o_br_sel;
  xlen_t     o_es_rs1_data, o_es_rs2_data, o_es_imm, o_es_pc, o_br_target;
  alu_op_t   o_es_alu_op;
  logic [1:0] o_es_alu_src2_sel;
  gpr_addr_t o_es_rd;

  integer seed = 32'hec51;
  xlen_t  rf [32];  // expected register contents

  `include "tb_id_vectors.svh"

  id_stage UUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  task automatic compare(input xlen_t got, input xlen_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_outputs(input vec_t v);
    compare(o_ds_to_es_valid, v.exp_valid, "valid");
    compare(o_es_rs1_data, v.exp_rs1, "rs1 data");
    compare(o_es_rs2_data, v.exp_rs2, "rs2 data");
    compare(o_es_imm, v.exp_imm, "immediate");
    compare(o_es_rd, v.exp_rd, "rd");
    compare({o_es_gpr_wen, o_es_mem_ren, o_es_mem_wen, o_es_load_sel, o_es_invalid},
            v.exp_en, "enables");
    compare({o_es_alu_op, o_es_alu_src1_sel, o_es_alu_src2_sel}, v.exp_alu, "alu controls");
    compare(o_es_pc, v.pc, "pc");
    compare(o_br_sel, v.exp_sel, "branch select");
    compare(o_br_taken, v.exp_taken, "branch taken");
    if (v.exp_sel) compare(o_br_target, v.exp_target, "branch target");
  endtask

  // empty the slot and wait until fetch may send
  task automatic drain();
    int n;
    n = 0;
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b0;
    i_es_byp_rd      <= '0;
    i_ms_byp_rd      <= '0;
    i_ws_byp_rd      <= '0;
    i_es_load_sel    <= 1'b0;
    i_es_allowin     <= 1'b1;
    @(negedge i_clk);
    while (!o_ds_allowin) begin
      if (n == WAIT_MAX) begin
        $display("timeout: decode stage never raised allowin");
        $display("Something failed");
        $fatal(1, "timeout");
      end
      n++;
      @(negedge i_clk);
    end
  endtask

  task automatic apply(input vec_t v);
    drain();
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b1;
    i_fs_inst        <= v.inst;
    i_fs_pc          <= v.pc;
    i_es_byp_rd      <= v.es_rd;
    i_ms_byp_rd      <= v.ms_rd;
    i_ws_byp_rd      <= v.ws_rd;
    i_es_load_sel    <= v.load;
    i_es_allowin     <= v.es_allowin;
    @(posedge i_clk);  // slot takes the entry here
    i_fs_pc          <= v.fs_pc;
    i_fs_to_ds_valid <= v.squash;
    i_fs_inst        <= 32'h002082B3;  // add x5, x1, x2
    @(negedge i_clk);
    check_outputs(v);
    if (v.load || !v.es_allowin) compare(o_ds_allowin, 0, "allowin while blocked");
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b0;
    i_es_load_sel    <= 1'b0;
    @(negedge i_clk);
    if (v.load) begin
      compare(o_ds_to_es_valid, 1, "valid after load drops");
    end else if (!v.es_allowin) begin
      check_outputs(v);
    end else if (v.squash) begin
      compare(o_ds_to_es_valid, 1, "squashed valid");
      compare(o_es_rd, 0, "squashed rd");
      compare({o_es_gpr_wen, o_es_mem_ren, o_es_mem_wen, o_es_invalid}, 0, "squashed enables");
      compare(o_es_pc, v.fs_pc, "squashed pc");
    end
  endtask

  initial begin
    xlen_t val;
    i_rst = 1'b1;
    i_es_allowin = 1'b1;
    i_fs_to_ds_valid = 1'b0;
    i_fs_inst = NOP_INST;
    i_fs_pc = '0;
    i_ws_gpr_wen = 1'b0;
    i_ws_gpr_waddr = '0;
    i_ws_gpr_wdata = '0;
    i_es_byp_rd = '0;
    i_ms_byp_rd = '0;
    i_ws_byp_rd = '0;
    i_es_byp_result = ES_VAL;
    i_ms_byp_result = MS_VAL;
    i_ws_byp_result = WS_VAL;
    i_es_load_sel = 1'b0;
    repeat (16) @(posedge i_clk);
    i_rst <= 1'b0;
    @(negedge i_clk);
    compare(o_ds_to_es_valid, 0, "valid after reset");
    compare(o_br_sel, 0, "select after reset");
    compare(o_br_taken, 0, "taken after reset");
    compare(o_ds_allowin, 1, "allowin after reset");
    // fill every register, x0 included
    for (int i = 0; i < 32; i++) begin
      @(posedge i_clk);
      val = {$random(seed), $random(seed)};
      i_ws_gpr_wen   <= 1'b1;
      i_ws_gpr_waddr <= i[4:0];
      i_ws_gpr_wdata <= val;
      rf[i] = (i == 0) ? '0 : val;
    end
    @(posedge i_clk);
    i_ws_gpr_wen <= 1'b0;
    build_vectors();
    foreach (vecs[i]) apply(vecs[i]);
    drain();
    if (UUT.u_asserts.fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("%0d assertion failures", UUT.u_asserts.fail_cnt);
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: testbench/id_stage_asserts.sv
// decode slot assertions
`timescale 1ns/1ps

module id_stage_asserts (
  input logic              i_clk,
  input logic              i_rst,
  input logic              i_es_allowin,
  input logic              i_fs_to_ds_valid,
  input id_pkg::xlen_t     i_fs_pc,
  input logic              i_es_load_sel,
  input logic              o_ds_allowin,
  input logic              o_ds_to_es_valid,
  input logic              o_br_taken,
  input logic              o_es_gpr_wen,
  input logic              o_es_mem_wen,
  input id_pkg::xlen_t     o_es_rs1_data,
  input id_pkg::xlen_t     o_es_rs2_data,
  input id_pkg::xlen_t     o_es_imm,
  input id_pkg::xlen_t     o_es_pc,
  input id_pkg::xlen_t     o_br_target,
  input id_pkg::gpr_addr_t o_es_rd
);

  int fail_cnt = 0;

  a_reset_empty: assert property (@(posedge i_clk) i_rst && $past(i_rst) |-> !o_ds_to_es_valid)
    else begin
      $error("valid raised during reset");
      fail_cnt++;
    end

  // wrong-path fetch lands as a nop at its own pc
  a_squash: assert property (@(posedge i_clk) disable iff (i_rst)
                             o_br_taken && i_fs_to_ds_valid && o_ds_allowin |=>
                             o_es_pc == $past(i_fs_pc) && o_es_rd == '0 &&
                             !o_es_gpr_wen && !o_es_mem_wen)
    else begin
      $error("wrong-path instruction not squashed");
      fail_cnt++;
    end

  a_accept_valid: assert property (@(posedge i_clk) disable iff (i_rst)
                                   i_fs_to_ds_valid && o_ds_allowin |=>
                                   o_ds_to_es_valid || i_es_load_sel)
    else begin
      $error("accepted instruction not valid without a load in execute");
      fail_cnt++;
    end

  // execute blocked, slot must hold
  a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
                           o_ds_to_es_valid && !i_es_allowin |=>
                           $stable({o_es_rs1_data, o_es_rs2_data, o_es_imm, o_es_pc,
                                    o_es_rd, o_br_target}))
    else begin
      $error("outputs moved under back-pressure");
      fail_cnt++;
    end

endmodule

bind id_stage id_stage_asserts u_asserts (.*);

// File: verilog.f
+incdir+testbench
design/id_pkg.sv
design/id_gpr_file.sv
design/id_operand_fetch.sv
design/id_decoder.sv
design/id_stage_ctrl.sv
design/id_branch_unit.sv
design/id_stage.sv
testbench/tb_id_stage.sv
testbench/id_stage_asserts.sv
